// ==== Makefile ====
# matrix-vector multiplier, Verilator simulation

TOP = mvm_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build and run the testbench, fails on a failing run"
	@echo "  clean  remove the build output"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module $(TOP) -f filelist.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== filelist.f ====
+incdir+source
source/mvm_pkg.sv
source/operand_store.sv
source/proc_element.sv
source/column_counter.sv
source/seq_ctrl.sv
source/result_buffer.sv
source/mvm_top.sv
tests/mvm_asserts.sv
tests/mvm_tb.sv

// ==== source/column_counter.sv ====
//////////////////////////////
// shared column counter
// last column flag against n
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module column_counter (
	input  logic        clk,
	input  logic        rst,
	input  logic        col_clr,  // sync clear, wins over enable
	input  logic        col_en,
	input  logic [3:0]  n,        // 1 .. 8
	output logic [2:0]  col,
	output logic        last_col
);

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			col <= 3'd0;
		else if (col_clr)
			col <= 3'd0;
		else if (col_en)
			col <= col + 3'd1; // wraps after col 7
	end

	// true on col = n-1
	assign last_col = ({1'b0, col} == n - 4'd1);

endmodule

`default_nettype wire

// ==== source/mvm_defines.svh ====
//////////////////////////////
// matrix-vector multiplier
// data and accumulator widths
// matrix size and pe count
//////////////////////////////

`ifndef MVM_DEFINES_SVH
`define MVM_DEFINES_SVH

// unsigned matrix and vector element
`define MVM_DATA_W 8

// row sum, wide enough for 8 full-scale products
`define MVM_ACC_W 20

// largest square matrix, 3-bit row and column index
`define MVM_MAX_N 8

// processing elements, also the row step between passes
`define MVM_NUM_PE 4

`endif

// ==== source/mvm_pkg.sv ====
//////////////////////////////
// shared types
// opcodes, controller states
// command, result, pe report
//////////////////////////////

`default_nettype none

`include "mvm_defines.svh"

package mvm_pkg;

	typedef enum logic [1:0] {
		OP_WRITE_MAT = 2'd0, // one matrix element at row, col
		OP_WRITE_VEC = 2'd1, // one vector element at col
		OP_RUN       = 2'd2  // start, n in data[3:0]
	} mvm_opcode_e;

	typedef enum logic [2:0] {
		S_IDLE    = 3'd0,
		S_ACK     = 3'd1, // cmd_ack high, wait for req low
		S_RELEASE = 3'd2, // clear before first pass
		S_PASS    = 3'd3, // one mac per column
		S_FLUSH   = 3'd4, // pe reports valid
		S_DELIVER = 3'd5  // result channel busy
	} ctrl_state_e;

	typedef struct packed {
		mvm_opcode_e             op;
		logic [2:0]              row;
		logic [2:0]              col;
		logic [`MVM_DATA_W-1:0]  data;
		logic                    rsvd; // unused
	} mvm_cmd_t;

	typedef struct packed {
		logic [2:0]              row;
		logic [`MVM_ACC_W-1:0]   value;
	} mvm_res_t;

	typedef struct packed {
		logic                    valid;  // flush cycle only
		logic [2:0]              row;
		logic                    row_ok; // row below n
		logic [`MVM_ACC_W-1:0]   value;
	} pe_out_t;

endpackage

`default_nettype wire

// ==== source/mvm_top.sv ====
//////////////////////////////
// matrix-vector multiplier top
// store, counter, fsm, 4 pes
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "mvm_defines.svh"

module mvm_top import mvm_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      cmd_req,
	input  mvm_cmd_t  cmd,
	input  logic      res_ack,
	output logic      cmd_ack,
	output logic      res_req,
	output mvm_res_t  res
);

	logic                                     mat_we;
	logic                                     vec_we;
	logic [3:0]                               n;
	logic                                     col_clr;
	logic                                     col_en;
	logic                                     pe_clr;
	logic                                     pe_en;
	logic                                     pass;
	logic                                     deliver_start;
	logic                                     deliver_done;
	logic [2:0]                               col;
	logic                                     last_col;
	logic [`MVM_NUM_PE-1:0][2:0]              pe_row;  // row address per pe
	logic [`MVM_NUM_PE-1:0][`MVM_DATA_W-1:0]  pe_mat;
	logic [`MVM_DATA_W-1:0]                   vec_col; // vector[col]
	pe_out_t [`MVM_NUM_PE-1:0]                pe_rep;

	seq_ctrl u_seq_ctrl (
		.clk           (clk),
		.rst           (rst),
		.cmd_req       (cmd_req),
		.cmd           (cmd),
		.last_col      (last_col),
		.deliver_done  (deliver_done),
		.cmd_ack       (cmd_ack),
		.mat_we        (mat_we),
		.vec_we        (vec_we),
		.n             (n),
		.col_clr       (col_clr),
		.col_en        (col_en),
		.pe_clr        (pe_clr),
		.pe_en         (pe_en),
		.pass          (pass),
		.deliver_start (deliver_start)
	);

	// write address and data straight from the held command
	operand_store u_operand_store (
		.clk     (clk),
		.rst     (rst),
		.mat_we  (mat_we),
		.vec_we  (vec_we),
		.wr_row  (cmd.row),
		.wr_col  (cmd.col),
		.wr_data (cmd.data),
		.rd_row  (pe_row),
		.rd_col  (col),
		.rd_mat  (pe_mat),
		.rd_vec  (vec_col)
	);

	column_counter u_column_counter (
		.clk      (clk),
		.rst      (rst),
		.col_clr  (col_clr),
		.col_en   (col_en),
		.n        (n),
		.col      (col),
		.last_col (last_col)
	);

	for (genvar p = 0; p < `MVM_NUM_PE; p++)
	begin : g_pe
		proc_element #(.pe_num(p)) u_proc_element (
			.clk      (clk),
			.rst      (rst),
			.pe_clr   (pe_clr),
			.pe_en    (pe_en),
			.pass     (pass),
			.n        (n),
			.mat_elem (pe_mat[p]),
			.vec_elem (vec_col),
			.row      (pe_row[p]),
			.pe_out   (pe_rep[p])
		);
	end

	result_buffer u_result_buffer (
		.clk           (clk),
		.rst           (rst),
		.pe_out        (pe_rep),
		.n             (n),
		.deliver_start (deliver_start),
		.res_ack       (res_ack),
		.res_req       (res_req),
		.res           (res),
		.deliver_done  (deliver_done)
	);

endmodule

`default_nettype wire

// ==== source/operand_store.sv ====
//////////////////////////////
// operand storage
// 8x8 matrix, 8-entry vector
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "mvm_defines.svh"

module operand_store (
	input  logic                                      clk,
	input  logic                                      rst,
	input  logic                                      mat_we,
	input  logic                                      vec_we,
	input  logic [2:0]                                wr_row,
	input  logic [2:0]                                wr_col,
	input  logic [`MVM_DATA_W-1:0]                    wr_data,
	input  logic [`MVM_NUM_PE-1:0][2:0]               rd_row,  // one row per pe
	input  logic [2:0]                                rd_col,  // shared column
	output logic [`MVM_NUM_PE-1:0][`MVM_DATA_W-1:0]   rd_mat,
	output logic [`MVM_DATA_W-1:0]                    rd_vec
);

	logic [`MVM_DATA_W-1:0] mat [`MVM_MAX_N][`MVM_MAX_N];
	logic [`MVM_DATA_W-1:0] vec [`MVM_MAX_N];

	// one element per accepted write command
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			for (int r = 0; r < `MVM_MAX_N; r++)
			begin
				vec[r] <= '0;
				for (int c = 0; c < `MVM_MAX_N; c++)
					mat[r][c] <= '0;
			end
		end
		else
		begin
			if (mat_we)
				mat[wr_row][wr_col] <= wr_data;
			if (vec_we)
				vec[wr_col] <= wr_data; // row field ignored
		end
	end

	// four matrix reads at the current column
	always_comb
	begin
		for (int p = 0; p < `MVM_NUM_PE; p++)
			rd_mat[p] = mat[rd_row[p]][rd_col];
	end

	assign rd_vec = vec[rd_col]; // same vector element for every pe

endmodule

`default_nettype wire

// ==== source/proc_element.sv ====
//////////////////////////////
// processing element
// row select per pass, mac
// flush report to result buffer
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "mvm_defines.svh"

module proc_element import mvm_pkg::*; #(
	parameter int pe_num = 0 // 0 .. MVM_NUM_PE-1
) (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      pe_clr,   // clear accumulator
	input  logic                      pe_en,    // one product per cycle
	input  logic                      pass,     // 0 first row, 1 second
	input  logic [3:0]                n,
	input  logic [`MVM_DATA_W-1:0]    mat_elem,
	input  logic [`MVM_DATA_W-1:0]    vec_elem,
	output logic [2:0]                row,
	output pe_out_t                   pe_out
);

	localparam logic [2:0] base_row   = 3'(pe_num);
	localparam logic [2:0] row_stride = 3'(`MVM_NUM_PE);

	logic [2*`MVM_DATA_W-1:0] product;
	logic [`MVM_ACC_W-1:0]    acc;
	logic                     en_q;   // pe_en last cycle
	logic                     flush;
	logic                     row_ok;

	// row p in pass 0, row p+4 in pass 1
	assign row = pass ? base_row + row_stride : base_row;

	// unsigned 8x8 product
	assign product = mat_elem * vec_elem;

	// only place the row is checked against n
	assign row_ok = {1'b0, row} < n;

	// first cycle after the enable window
	assign flush = en_q & ~pe_en;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			en_q <= 1'b0;
		else
			en_q <= pe_en;
	end

	// row sum, cleared at the start of each pass
	always_ff @(posedge clk)
	begin
		if (pe_clr)
			acc <= '0;
		else if (pe_en)
			acc <= acc + `MVM_ACC_W'(product);
	end

	// report held in acc, valid for the flush cycle
	always_comb
	begin
		pe_out.valid  = flush;
		pe_out.row    = row;
		pe_out.row_ok = row_ok;
		pe_out.value  = acc;
	end

endmodule

`default_nettype wire

// ==== source/result_buffer.sv ====
//////////////////////////////
// result buffer
// row results in, 4-phase out
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "mvm_defines.svh"

module result_buffer import mvm_pkg::*; (
	input  logic                       clk,
	input  logic                       rst,
	input  pe_out_t [`MVM_NUM_PE-1:0]  pe_out,
	input  logic [3:0]                 n,
	input  logic                       deliver_start,
	input  logic                       res_ack,
	output logic                       res_req,
	output mvm_res_t                   res,
	output logic                       deliver_done
);

	logic [`MVM_ACC_W-1:0] row_val [`MVM_MAX_N];
	logic                  active;     // delivery in progress
	logic [3:0]            sent;       // rows offered so far
	logic                  idle_ph;    // req and ack both low
	logic                  offer_next;
	logic                  finish;

	assign idle_ph    = active & ~res_req & ~res_ack;
	assign offer_next = idle_ph & (sent != n);
	assign finish     = idle_ph & (sent == n); // last ack has fallen

	// keep reports for rows below n
	always_ff @(posedge clk)
	begin
		for (int i = 0; i < `MVM_NUM_PE; i++)
			if (pe_out[i].valid && pe_out[i].row_ok)
				row_val[pe_out[i].row] <= pe_out[i].value;
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			active       <= 1'b0;
			sent         <= 4'd0;
			res_req      <= 1'b0;
			deliver_done <= 1'b0;
		end
		else
		begin
			deliver_done <= 1'b0;
			if (deliver_start)
			begin
				active  <= 1'b1;
				sent    <= 4'd1;  // row 0 goes out at once
				res_req <= 1'b1;
			end
			else if (res_req && res_ack)
				res_req <= 1'b0;  // drop one cycle after ack
			else if (offer_next)
			begin
				res_req <= 1'b1;
				sent    <= sent + 4'd1;
			end
			else if (finish)
			begin
				active       <= 1'b0;
				deliver_done <= 1'b1;
			end
		end
	end

	// payload loads with each offer, stable while req high
	always_ff @(posedge clk)
	begin
		if (deliver_start)
		begin
			res.row   <= 3'd0;
			res.value <= row_val[0];
		end
		else if (offer_next)
		begin
			res.row   <= sent[2:0];
			res.value <= row_val[sent[2:0]];
		end
	end

endmodule

`default_nettype wire

// ==== source/seq_ctrl.sv ====
//////////////////////////////
// sequencing fsm
// command accept, passes
// hand-off to delivery
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "mvm_defines.svh"

module seq_ctrl import mvm_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        cmd_req,
	input  mvm_cmd_t    cmd,
	input  logic        last_col,
	input  logic        deliver_done,
	output logic        cmd_ack,
	output logic        mat_we,
	output logic        vec_we,
	output logic [3:0]  n,
	output logic        col_clr,
	output logic        col_en,
	output logic        pe_clr,
	output logic        pe_en,
	output logic        pass,
	output logic        deliver_start
);

	ctrl_state_e state;
	logic        accept;   // new command seen this cycle
	logic [3:0]  run_n;
	logic        run_ok;   // run with 1 <= n <= 8
	logic        run_q;    // acked command was a run

	assign accept = (state == S_IDLE) && cmd_req;
	assign run_n  = cmd.data[3:0];
	assign run_ok = (cmd.op == OP_RUN) && (run_n != 4'd0) && (run_n <= 4'(`MVM_MAX_N));

	// writes happen in the accept cycle, ack follows
	assign mat_we = accept && (cmd.op == OP_WRITE_MAT);
	assign vec_we = accept && (cmd.op == OP_WRITE_VEC);

	// clear on entry to every pass
	assign col_clr = (state == S_RELEASE) || (state == S_FLUSH);
	assign pe_clr  = col_clr;
	assign col_en  = (state == S_PASS);
	assign pe_en   = col_en;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			state         <= S_IDLE;
			cmd_ack       <= 1'b0;
			run_q         <= 1'b0;
			n             <= 4'd0;
			pass          <= 1'b0;
			deliver_start <= 1'b0;
		end
		else
		begin
			deliver_start <= 1'b0; // single pulse
			case (state)
				S_IDLE:
					if (cmd_req)
					begin
						cmd_ack <= 1'b1;
						run_q   <= run_ok;
						if (run_ok)
							n <= run_n; // held until next run
						state   <= S_ACK;
					end
				S_ACK:
					if (!cmd_req)
					begin
						cmd_ack <= 1'b0;
						state   <= run_q ? S_RELEASE : S_IDLE;
					end
				S_RELEASE:
				begin
					pass  <= 1'b0;
					state <= S_PASS;
				end
				S_PASS:
					if (last_col)
						state <= S_FLUSH;
				S_FLUSH:
					if (!pass && (n > 4'(`MVM_NUM_PE)))
					begin
						pass  <= 1'b1; // rows 4 .. n-1
						state <= S_PASS;
					end
					else
					begin
						deliver_start <= 1'b1;
						state         <= S_DELIVER;
					end
				S_DELIVER:
					if (deliver_done)
					begin
						run_q <= 1'b0;
						state <= S_IDLE;
					end
				default:
					state <= S_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== tests/mvm_asserts.sv ====
//////////////////////////////
// handshake and reset checks
// bound into seq_ctrl, result_buffer
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module mvm_asserts import mvm_pkg::*; (
	input logic        clk,
	input logic        rst,
	input logic        cmd_req,
	input logic        cmd_ack,
	input ctrl_state_e state,    // tied to S_IDLE outside seq_ctrl
	input logic        res_req,
	input logic        res_ack,
	input mvm_res_t    res
);

	// ack only ever answers a pending request
	cmd_ack_needs_req: assert property (@(posedge clk) disable iff (!rst)
		$rose(cmd_ack) |-> $past(cmd_req))
		else $error("cmd_ack rose with no cmd_req before it");

	// payload frozen for the whole req phase
	res_held_during_req: assert property (@(posedge clk) disable iff (!rst)
		($past(res_req) && res_req) |-> $stable(res))
		else $error("res changed while res_req was high");

	// req drops only once the host has acked
	res_req_waits_ack: assert property (@(posedge clk) disable iff (!rst)
		$fell(res_req) |-> $past(res_ack))
		else $error("res_req fell before res_ack was seen");

	// quiet outputs and idle fsm while in reset
	reset_state: assert property (@(posedge clk)
		!rst |-> (!cmd_ack && !res_req && (state == S_IDLE)))
		else $error("outputs or state not cleared during reset");

endmodule

`default_nettype wire

// ==== tests/mvm_tb.sv ====
//////////////////////////////
// testbench for mvm_top
// host driver, reference sums
// result receiver and checks
//////////////////////////////

`timescale 1ns/100ps
`default_nettype none

`include "mvm_defines.svh"

module mvm_tb import mvm_pkg::*; ();

	localparam int wait_limit = 2000; // cycles, per wait loop
	localparam int drive_dly  = 1;    // ns after rising edge

	logic     clk;
	logic     rst;
	logic     cmd_req;
	mvm_cmd_t cmd;
	logic     cmd_ack;
	logic     res_req;
	logic     res_ack;
	mvm_res_t res;

	logic [`MVM_DATA_W-1:0] mat_ref [`MVM_MAX_N][`MVM_MAX_N]; // host copy
	logic [`MVM_DATA_W-1:0] vec_ref [`MVM_MAX_N];
	mvm_res_t               exp_q [$]; // results still owed, row order
	int                     got_total;
	int                     exp_total;

	mvm_top u_mvm_top (
		.clk     (clk),
		.rst     (rst),
		.cmd_req (cmd_req),
		.cmd     (cmd),
		.res_ack (res_ack),
		.cmd_ack (cmd_ack),
		.res_req (res_req),
		.res     (res)
	);

	bind seq_ctrl mvm_asserts u_ctrl_asserts (
		.clk     (clk),
		.rst     (rst),
		.cmd_req (cmd_req),
		.cmd_ack (cmd_ack),
		.state   (state),
		.res_req (1'b0),
		.res_ack (1'b0),
		.res     ('0)
	);

	bind result_buffer mvm_asserts u_res_asserts (
		.clk     (clk),
		.rst     (rst),
		.cmd_req (1'b0),
		.cmd_ack (1'b0),
		.state   (mvm_pkg::S_IDLE),
		.res_req (res_req),
		.res_ack (res_ack),
		.res     (res)
	);

	always #2 clk = ~clk; // 4 ns period

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	// one edge, then settle before driving or sampling
	task automatic next_cycle();
		@(posedge clk);
		#drive_dly;
	endtask

	// row r of matrix times vector over the first size columns
	function automatic logic [`MVM_ACC_W-1:0] row_sum(input int r, input int size);
		int acc;
		acc = 0;
		for (int c = 0; c < size; c++)
			acc += int'(mat_ref[r][c]) * int'(vec_ref[c]);
		return `MVM_ACC_W'(acc);
	endfunction

	// four-phase command, cmd held while req high
	task automatic send_cmd(input mvm_opcode_e op, input logic [2:0] row,
		input logic [2:0] col, input logic [7:0] data);
		int waited;
		cmd.op   = op;
		cmd.row  = row;
		cmd.col  = col;
		cmd.data = data;
		cmd.rsvd = 1'b0;
		cmd_req  = 1'b1;
		waited   = 0;
		while (!cmd_ack && waited < wait_limit)
		begin
			next_cycle();
			waited++;
		end
		assert (cmd_ack) else abort_run("command was not acknowledged in time");
		cmd_req = 1'b0;
		waited  = 0;
		while (cmd_ack && waited < wait_limit)
		begin
			next_cycle();
			waited++;
		end
		assert (!cmd_ack) else abort_run("cmd_ack stayed high after cmd_req fell");
	endtask

	task automatic write_mat(input logic [2:0] r, input logic [2:0] c, input logic [7:0] v);
		mat_ref[r][c] = v;
		send_cmd(OP_WRITE_MAT, r, c, v);
	endtask

	task automatic write_vec(input logic [2:0] c, input logic [7:0] v);
		vec_ref[c] = v;
		send_cmd(OP_WRITE_VEC, 3'd0, c, v);
	endtask

	task automatic load_random();
		for (int r = 0; r < `MVM_MAX_N; r++)
			for (int c = 0; c < `MVM_MAX_N; c++)
				write_mat(3'(r), 3'(c), 8'($urandom));
		for (int c = 0; c < `MVM_MAX_N; c++)
			write_vec(3'(c), 8'($urandom));
	endtask

	// queue the expected rows, start the run, wait for every result
	task automatic run_check(input int size);
		mvm_res_t want;
		int       waited;
		for (int r = 0; r < size; r++)
		begin
			want.row   = 3'(r);
			want.value = row_sum(r, size);
			exp_q.push_back(want);
		end
		exp_total += size;
		send_cmd(OP_RUN, 3'd0, 3'd0, 8'(size));
		waited = 0;
		while (got_total != exp_total && waited < wait_limit)
		begin
			next_cycle();
			waited++;
		end
		assert (got_total == exp_total)
			else abort_run($sformatf("run of size %0d did not return all results", size));
	endtask

	// host side of the result channel
	initial
	begin : receive_results
		mvm_res_t got;
		mvm_res_t want;
		int       idle;
		int       delay;
		int       waited;
		idle = 0;
		forever
		begin
			next_cycle();
			if (res_req)
			begin
				idle = 0;
				got  = res;
				assert (exp_q.size() != 0) else abort_run("result offered when none was owed");
				want = exp_q.pop_front();
				assert (got == want)
					else abort_run($sformatf("ERROR at %0t: got row %0d value %0d, expected row %0d value %0d",
						$time, got.row, got.value, want.row, want.value));
				delay = $urandom_range(4, 0); // slow host now and then
				repeat (delay) next_cycle();
				res_ack = 1'b1;
				waited  = 0;
				while (res_req && waited < wait_limit)
				begin
					next_cycle();
					waited++;
				end
				assert (!res_req) else abort_run("res_req did not fall after res_ack");
				res_ack = 1'b0;
				got_total++;
			end
			else if (exp_q.size() != 0)
			begin
				idle++;
				assert (idle < wait_limit) else abort_run("no result offered while results were owed");
			end
			else
				idle = 0;
		end
	end

	initial
	begin : main_sequence
		clk       = 1'b0;
		rst       = 1'b0;
		cmd_req   = 1'b0;
		cmd       = '0;
		res_ack   = 1'b0;
		got_total = 0;
		exp_total = 0;
		void'($urandom(32'hb735_f8fd));
		repeat (3) @(posedge clk); // reset for 3 cycles
		#drive_dly;
		rst = 1'b1;
		next_cycle();

		// identity matrix, vector comes back as is
		for (int r = 0; r < `MVM_MAX_N; r++)
			for (int c = 0; c < `MVM_MAX_N; c++)
				write_mat(3'(r), 3'(c), (r == c) ? 8'd1 : 8'd0);
		for (int c = 0; c < `MVM_MAX_N; c++)
			write_vec(3'(c), 8'($urandom));
		run_check(8);

		// single pass sizes
		for (int s = 1; s <= `MVM_NUM_PE; s++)
		begin
			load_random();
			run_check(s);
		end

		// two passes, rows 4 and up
		for (int s = `MVM_NUM_PE + 1; s <= `MVM_MAX_N; s++)
		begin
			load_random();
			run_check(s);
		end

		// full scale, 8 * 255 * 255 per row
		for (int r = 0; r < `MVM_MAX_N; r++)
			for (int c = 0; c < `MVM_MAX_N; c++)
				write_mat(3'(r), 3'(c), 8'd255);
		for (int c = 0; c < `MVM_MAX_N; c++)
			write_vec(3'(c), 8'd255);
		run_check(8);

		// one element rewritten, only row 6 moves
		load_random();
		write_vec(3'd2, vec_ref[2] | 8'd1); // nonzero so row 6 sees the change
		run_check(8);
		write_mat(3'd6, 3'd2, mat_ref[6][2] ^ 8'h5a);
		run_check(8);

		repeat (20) next_cycle(); // room for a stray extra result
		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire
